/* verilog/fpx_pkg.sv */
package fpx_pkg;

    // register file and tag widths
    localparam int REG_ADDR_BITS = 5;
    localparam int OFFSET_ADDR_BITS = 3;
    localparam int WORD_BITS = 32;

    // scratchpad geometry
    localparam int MEM_WORDS = 1024;
    localparam int MEM_ADDR_BITS = 10;

    // quiet nan returned when no operand is usable
    localparam logic [WORD_BITS-1:0] CANONICAL_NAN = 32'h7fc0_0000;

    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [OFFSET_ADDR_BITS-1:0] offset_addr_t;
    typedef logic [WORD_BITS-1:0] word_t;

    typedef enum logic [1:0] {
        CONVERT_OP_MIN = 2'b00,
        CONVERT_OP_MAX = 2'b01,
        CONVERT_OP_RAW = 2'b10,
        CONVERT_OP_CNV = 2'b11
    } convert_op_t;

    typedef enum logic {
        MEMORY_OP_LOAD = 1'b0,
        MEMORY_OP_STORE = 1'b1
    } memory_op_t;

    // one writeback item, shared by both pipelines
    typedef struct packed {
        reg_addr_t dest_reg_addr;
        offset_addr_t dest_offset_addr;
        word_t value;
    } result_t;

endpackage

/* verilog/stream_stage.sv */
`timescale 1ns/1ps

module stream_stage #(
    parameter type T = logic
) (
    input logic clk,
    input logic rst,

    input logic in_valid,
    output logic in_ready,
    input T in_data,

    output logic out_valid,
    input logic out_ready,
    output T out_data
);

    // free when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
        end
    end

    // payload only moves on an accepted item
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            out_data <= in_data;
        end
    end

endmodule

/* verilog/fp_convert.sv */
`timescale 1ns/1ps

module fp_convert (
    input logic clk,
    input logic rst,

    input logic cvt_valid,
    output logic cvt_ready,
    input fpx_pkg::reg_addr_t cvt_dest_reg,
    input fpx_pkg::offset_addr_t cvt_dest_offset,
    input fpx_pkg::word_t cvt_a,
    input fpx_pkg::word_t cvt_b,
    input fpx_pkg::convert_op_t cvt_op,
    input logic cvt_signed,

    output logic res_valid,
    input logic res_ready,
    output fpx_pkg::result_t res
);

    logic s1_valid;
    logic s1_ready;
    fpx_pkg::result_t s1_res;

    logic a_nan, b_nan, a_lt_b;
    fpx_pkg::word_t min_val, max_val;

    logic int_neg;
    fpx_pkg::word_t int_mag, norm;
    logic [4:0] lz;
    logic [30:0] packed_exp_man;
    logic round_up;
    fpx_pkg::word_t cnv_val;
    fpx_pkg::word_t op_val;

    // position of the leading one counted from bit 31
    function automatic logic [4:0] lead_zeros(input fpx_pkg::word_t v);
        logic [4:0] n;
        n = 5'd0;
        for (int i = 0; i < 32; i++)
        begin
            if (v[i])
            begin
                n = 5'(31 - i);
            end
        end
        return n;
    endfunction

    assign a_nan = (cvt_a[30:23] == 8'hff) && (cvt_a[22:0] != 23'd0);
    assign b_nan = (cvt_b[30:23] == 8'hff) && (cvt_b[22:0] != 23'd0);

    // sign-magnitude ordering, so -0 sits below +0
    always_comb
    begin
        if (cvt_a[31] != cvt_b[31])
            a_lt_b = cvt_a[31];
        else if (cvt_a[31])
            a_lt_b = cvt_a[30:0] > cvt_b[30:0];
        else
            a_lt_b = cvt_a[30:0] < cvt_b[30:0];
    end

    always_comb
    begin
        if (a_nan && b_nan)
        begin
            min_val = fpx_pkg::CANONICAL_NAN;
            max_val = fpx_pkg::CANONICAL_NAN;
        end
        else if (a_nan || b_nan)
        begin
            // the number wins over the nan
            min_val = a_nan ? cvt_b : cvt_a;
            max_val = a_nan ? cvt_b : cvt_a;
        end
        else
        begin
            min_val = a_lt_b ? cvt_a : cvt_b;
            max_val = a_lt_b ? cvt_b : cvt_a;
        end
    end

    // integer to single, round to nearest even
    assign int_neg = cvt_signed && cvt_a[31];
    assign int_mag = int_neg ? -cvt_a : cvt_a;
    assign lz = lead_zeros(int_mag);
    assign norm = int_mag << lz;
    assign round_up = norm[7] && ((|norm[6:0]) || norm[8]);
    // mantissa overflow carries straight into the exponent field
    assign packed_exp_man = {8'd158 - {3'd0, lz}, norm[30:8]} + {30'd0, round_up};
    assign cnv_val = (int_mag == 32'd0) ? 32'd0 : {int_neg, packed_exp_man};

    always_comb
    begin
        case (cvt_op)
            fpx_pkg::CONVERT_OP_MIN: op_val = min_val;
            fpx_pkg::CONVERT_OP_MAX: op_val = max_val;
            fpx_pkg::CONVERT_OP_RAW: op_val = cvt_a;
            default: op_val = cnv_val;
        endcase
    end

    assign cvt_ready = !s1_valid || s1_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
            s1_valid <= 1'b0;
        else if (cvt_ready)
            s1_valid <= cvt_valid;
    end

    always_ff @(posedge clk)
    begin
        if (cvt_valid && cvt_ready)
            s1_res <= '{dest_reg_addr: cvt_dest_reg, dest_offset_addr: cvt_dest_offset,
                        value: op_val};
    end

    stream_stage #(
        .T(fpx_pkg::result_t)
    ) out_stage (
        .clk(clk),
        .rst(rst),
        .in_valid(s1_valid),
        .in_ready(s1_ready),
        .in_data(s1_res),
        .out_valid(res_valid),
        .out_ready(res_ready),
        .out_data(res)
    );

endmodule

/* verilog/fp_memory.sv */
`timescale 1ns/1ps

module fp_memory (
    input logic clk,
    input logic rst,

    input logic mem_valid,
    output logic mem_ready,
    input fpx_pkg::reg_addr_t mem_dest_reg,
    input fpx_pkg::offset_addr_t mem_dest_offset,
    input fpx_pkg::memory_op_t mem_op,
    input fpx_pkg::word_t mem_data,
    input fpx_pkg::word_t mem_base,
    input fpx_pkg::word_t mem_offset,

    output logic res_valid,
    input logic res_ready,
    output fpx_pkg::result_t res
);

    fpx_pkg::word_t scratch [fpx_pkg::MEM_WORDS];

    fpx_pkg::word_t byte_addr;
    logic [fpx_pkg::MEM_ADDR_BITS-1:0] word_addr;
    logic accept, is_store;

    // access stage, holds loads only
    logic s1_valid;
    logic s1_ready;
    fpx_pkg::reg_addr_t s1_reg;
    fpx_pkg::offset_addr_t s1_off;
    fpx_pkg::word_t rd_data;

    assign byte_addr = mem_base + mem_offset;
    assign word_addr = byte_addr[11:2];

    assign mem_ready = !s1_valid || s1_ready;
    assign accept = mem_valid && mem_ready;
    assign is_store = (mem_op == fpx_pkg::MEMORY_OP_STORE);

    always_ff @(posedge clk)
    begin
        if (accept && is_store)
            scratch[word_addr] <= mem_data;
    end

    // synchronous read, tags travel alongside
    always_ff @(posedge clk)
    begin
        if (accept && !is_store)
        begin
            rd_data <= scratch[word_addr];
            s1_reg <= mem_dest_reg;
            s1_off <= mem_dest_offset;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            s1_valid <= 1'b0;
        else if (mem_ready)
            s1_valid <= mem_valid && !is_store;
    end

    stream_stage #(
        .T(fpx_pkg::result_t)
    ) out_stage (
        .clk(clk),
        .rst(rst),
        .in_valid(s1_valid),
        .in_ready(s1_ready),
        .in_data('{dest_reg_addr: s1_reg, dest_offset_addr: s1_off, value: rd_data}),
        .out_valid(res_valid),
        .out_ready(res_ready),
        .out_data(res)
    );

endmodule

/* verilog/writeback_arbiter.sv */
`timescale 1ns/1ps

module writeback_arbiter (
    input logic clk,
    input logic rst,

    input logic a_valid,
    output logic a_ready,
    input fpx_pkg::result_t a_data,

    input logic b_valid,
    output logic b_ready,
    input fpx_pkg::result_t b_data,

    output logic wb_valid,
    input logic wb_ready,
    output fpx_pkg::result_t wb_result
);

    // prefer_b low means input a wins a tie
    logic prefer_b;
    logic out_free;
    logic grant_a, grant_b;

    assign out_free = !wb_valid || wb_ready;
    assign grant_a = a_valid && (!b_valid || !prefer_b);
    assign grant_b = b_valid && (!a_valid || prefer_b);

    assign a_ready = out_free && grant_a;
    assign b_ready = out_free && grant_b;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_valid <= 1'b0;
            prefer_b <= 1'b0;
        end
        else
        begin
            if (out_free)
                wb_valid <= a_valid || b_valid;
            // flip only when both sides were waiting
            if (out_free && a_valid && b_valid)
                prefer_b <= !prefer_b;
        end
    end

    always_ff @(posedge clk)
    begin
        if (a_ready)
            wb_result <= a_data;
        else if (b_ready)
            wb_result <= b_data;
    end

endmodule

/* verilog/fp_unit_top.sv */
`timescale 1ns/1ps

module fp_unit_top (
    input logic clk,
    input logic rst,

    input logic cvt_valid,
    output logic cvt_ready,
    input fpx_pkg::reg_addr_t cvt_dest_reg,
    input fpx_pkg::offset_addr_t cvt_dest_offset,
    input fpx_pkg::word_t cvt_a,
    input fpx_pkg::word_t cvt_b,
    input fpx_pkg::convert_op_t cvt_op,
    input logic cvt_signed,

    input logic mem_valid,
    output logic mem_ready,
    input fpx_pkg::reg_addr_t mem_dest_reg,
    input fpx_pkg::offset_addr_t mem_dest_offset,
    input fpx_pkg::memory_op_t mem_op,
    input fpx_pkg::word_t mem_data,
    input fpx_pkg::word_t mem_base,
    input fpx_pkg::word_t mem_offset,

    output logic wb_valid,
    input logic wb_ready,
    output fpx_pkg::result_t wb_result
);

    logic cvt_res_valid, cvt_res_ready;
    fpx_pkg::result_t cvt_res;
    logic ld_res_valid, ld_res_ready;
    fpx_pkg::result_t ld_res;

    fp_convert u_convert (
        .clk(clk), .rst(rst),
        .cvt_valid(cvt_valid), .cvt_ready(cvt_ready),
        .cvt_dest_reg(cvt_dest_reg), .cvt_dest_offset(cvt_dest_offset),
        .cvt_a(cvt_a), .cvt_b(cvt_b), .cvt_op(cvt_op), .cvt_signed(cvt_signed),
        .res_valid(cvt_res_valid), .res_ready(cvt_res_ready), .res(cvt_res)
    );

    fp_memory u_memory (
        .clk(clk), .rst(rst),
        .mem_valid(mem_valid), .mem_ready(mem_ready),
        .mem_dest_reg(mem_dest_reg), .mem_dest_offset(mem_dest_offset),
        .mem_op(mem_op), .mem_data(mem_data),
        .mem_base(mem_base), .mem_offset(mem_offset),
        .res_valid(ld_res_valid), .res_ready(ld_res_ready), .res(ld_res)
    );

    // convert results on a, load results on b
    writeback_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .a_valid(cvt_res_valid), .a_ready(cvt_res_ready), .a_data(cvt_res),
        .b_valid(ld_res_valid), .b_ready(ld_res_ready), .b_data(ld_res),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_result(wb_result)
    );

endmodule

/* sim/fp_unit_tb.sv */
`timescale 1ns/1ps

module fp_unit_tb;

    localparam int RESET_CYCLES = 16;
    localparam int N_CVT = 600;
    localparam int N_MEM = 400;

    logic clk = 1'b0;
    logic rst;
    logic cvt_valid, cvt_ready, cvt_signed;
    fpx_pkg::reg_addr_t cvt_dest_reg;
    fpx_pkg::offset_addr_t cvt_dest_offset;
    fpx_pkg::word_t cvt_a, cvt_b;
    fpx_pkg::convert_op_t cvt_op;
    logic mem_valid, mem_ready;
    fpx_pkg::reg_addr_t mem_dest_reg;
    fpx_pkg::offset_addr_t mem_dest_offset;
    fpx_pkg::memory_op_t mem_op;
    fpx_pkg::word_t mem_data, mem_base, mem_offset;
    logic wb_valid, wb_ready;
    fpx_pkg::result_t wb_result;

    fpx_pkg::word_t lcg_state = 32'hbff5_574b;
    fpx_pkg::word_t model_mem [fpx_pkg::MEM_WORDS];
    logic [fpx_pkg::MEM_ADDR_BITS-1:0] stored_addrs [$];
    fpx_pkg::result_t cvt_q [$];
    fpx_pkg::result_t ld_q [$];
    fpx_pkg::offset_addr_t tag_cnt = '0;
    logic cvt_fire = 1'b0;
    logic mem_fire = 1'b0;
    int cvt_sent = 0;
    int mem_sent = 0;

    fp_unit_top DUT (
        .clk(clk), .rst(rst),
        .cvt_valid(cvt_valid), .cvt_ready(cvt_ready),
        .cvt_dest_reg(cvt_dest_reg), .cvt_dest_offset(cvt_dest_offset),
        .cvt_a(cvt_a), .cvt_b(cvt_b), .cvt_op(cvt_op), .cvt_signed(cvt_signed),
        .mem_valid(mem_valid), .mem_ready(mem_ready),
        .mem_dest_reg(mem_dest_reg), .mem_dest_offset(mem_dest_offset),
        .mem_op(mem_op), .mem_data(mem_data),
        .mem_base(mem_base), .mem_offset(mem_offset),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_result(wb_result)
    );

    always #5 clk = !clk;

    function automatic fpx_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only, the low ones of an lcg repeat quickly
    function automatic int rand_below(input int n);
        return int'(lcg_next() >> 8) % n;
    endfunction

    function automatic fpx_pkg::word_t pick_float();
        fpx_pkg::word_t r;
        r = lcg_next();
        case (rand_below(8))
            0, 1: return {r[31], 31'd0};
            2: return {r[31], 8'hff, 23'd0};
            3: return {r[31], 8'hff, r[22:0] | 23'd1};
            4: return r & 32'h0000_000f;
            default: return r;
        endcase
    endfunction

    function automatic fpx_pkg::word_t pick_int();
        fpx_pkg::word_t r;
        r = lcg_next();
        case (rand_below(6))
            0: return 32'd0;
            1: return 32'h8000_0000;
            2: return r & 32'h0000_00ff;
            3: return r | 32'h0100_0000;
            default: return r;
        endcase
    endfunction

    function automatic logic is_nan(input fpx_pkg::word_t w);
        return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
    endfunction

    // monotonic unsigned key for non-nan floats, -0 lands just below +0
    function automatic fpx_pkg::word_t order_key(input fpx_pkg::word_t w);
        return w[31] ? ~w : (w | 32'h8000_0000);
    endfunction

    function automatic fpx_pkg::word_t model_minmax(input fpx_pkg::word_t a,
                                                    input fpx_pkg::word_t b, input logic want_max);
        if (is_nan(a) && is_nan(b))
            return fpx_pkg::CANONICAL_NAN;
        if (is_nan(a))
            return b;
        if (is_nan(b))
            return a;
        if ((order_key(a) < order_key(b)) != want_max)
            return a;
        return b;
    endfunction

    function automatic fpx_pkg::word_t model_cnv(input fpx_pkg::word_t a, input logic sgn);
        logic neg;
        fpx_pkg::word_t m32;
        logic [63:0] mag, kept, rem, half;
        int msb, shift, e;
        neg = sgn && a[31];
        m32 = neg ? (~a + 32'd1) : a;
        mag = {32'd0, m32};
        if (m32 == 32'd0)
            return 32'd0;
        msb = 0;
        for (int i = 0; i < 32; i++)
        begin
            if (m32[i])
                msb = i;
        end
        e = 127 + msb;
        kept = mag << (23 - msb);
        if (msb > 23)
        begin
            shift = msb - 23;
            kept = mag >> shift;
            rem = mag & ((64'd1 << shift) - 64'd1);
            half = 64'd1 << (shift - 1);
            if (rem > half || (rem == half && kept[0]))
                kept = kept + 64'd1;
            // rounding up to 2.0 bumps the exponent
            if (kept[24])
            begin
                kept = kept >> 1;
                e = e + 1;
            end
        end
        return {neg, 8'(e), kept[22:0]};
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input fpx_pkg::word_t got, input fpx_pkg::word_t expected,
                              input string what);
        if (got !== expected)
        begin
            $display("Fail at %0t: %s value %h, expected %h", $time, what, got, expected);
            abort_run();
        end
    endtask

    task automatic check_result(input fpx_pkg::result_t got, input fpx_pkg::result_t expected,
                                input string what);
        if (got.dest_reg_addr !== expected.dest_reg_addr
            || got.dest_offset_addr !== expected.dest_offset_addr)
        begin
            $display("Fail at %0t: %s tags %0d/%0d, expected %0d/%0d", $time, what,
                     got.dest_reg_addr, got.dest_offset_addr,
                     expected.dest_reg_addr, expected.dest_offset_addr);
            abort_run();
        end
        else
            check_word(got.value, expected.value, what);
    endtask

    // runs 1 ns after the rising edge
    task automatic drive_step();
        int idx;
        if (cvt_fire)
            cvt_valid = 1'b0;
        if (mem_fire)
            mem_valid = 1'b0;
        wb_ready = (rand_below(4) != 0);
        if (!cvt_valid && cvt_sent < N_CVT && rand_below(3) != 0)
        begin
            cvt_op = fpx_pkg::convert_op_t'(rand_below(4));
            cvt_signed = rand_below(2) != 0;
            cvt_a = (cvt_op == fpx_pkg::CONVERT_OP_CNV) ? pick_int() : pick_float();
            cvt_b = pick_float();
            cvt_dest_reg = 5'(rand_below(16));
            cvt_dest_offset = tag_cnt;
            tag_cnt = tag_cnt + 1'b1;
            cvt_valid = 1'b1;
        end
        if (!mem_valid && mem_sent < N_MEM && rand_below(3) != 0)
        begin
            mem_dest_reg = 5'(16 + rand_below(16));
            mem_dest_offset = tag_cnt;
            tag_cnt = tag_cnt + 1'b1;
            mem_data = pick_float();
            mem_base = lcg_next();
            if (stored_addrs.size() == 0 || rand_below(2) == 0)
            begin
                mem_op = fpx_pkg::MEMORY_OP_STORE;
                mem_offset = lcg_next();
            end
            else
            begin
                mem_op = fpx_pkg::MEMORY_OP_LOAD;
                // often reread the newest store
                idx = (rand_below(4) == 0) ? stored_addrs.size() - 1
                                           : rand_below(stored_addrs.size());
                mem_offset = {20'd0, stored_addrs[idx], 2'(rand_below(4))} - mem_base;
            end
            mem_valid = 1'b1;
        end
    endtask

    // runs at the falling edge, handshakes complete at the next rising edge
    task automatic sample_step();
        fpx_pkg::result_t expected;
        fpx_pkg::word_t byte_addr;
        cvt_fire = cvt_valid && cvt_ready;
        mem_fire = mem_valid && mem_ready;
        if (cvt_fire)
        begin
            expected.dest_reg_addr = cvt_dest_reg;
            expected.dest_offset_addr = cvt_dest_offset;
            case (cvt_op)
                fpx_pkg::CONVERT_OP_MIN: expected.value = model_minmax(cvt_a, cvt_b, 1'b0);
                fpx_pkg::CONVERT_OP_MAX: expected.value = model_minmax(cvt_a, cvt_b, 1'b1);
                fpx_pkg::CONVERT_OP_RAW: expected.value = cvt_a;
                default: expected.value = model_cnv(cvt_a, cvt_signed);
            endcase
            cvt_q.push_back(expected);
            cvt_sent++;
        end
        if (mem_fire)
        begin
            byte_addr = mem_base + mem_offset;
            if (mem_op == fpx_pkg::MEMORY_OP_STORE)
            begin
                model_mem[byte_addr[11:2]] = mem_data;
                stored_addrs.push_back(byte_addr[11:2]);
            end
            else
            begin
                expected.dest_reg_addr = mem_dest_reg;
                expected.dest_offset_addr = mem_dest_offset;
                expected.value = model_mem[byte_addr[11:2]];
                ld_q.push_back(expected);
            end
            mem_sent++;
        end
        if (wb_valid && wb_ready)
        begin
            if (wb_result.dest_reg_addr[4] ? ld_q.size() == 0 : cvt_q.size() == 0)
            begin
                $display("writeback at %0t to register %0d with nothing outstanding for it",
                         $time, wb_result.dest_reg_addr);
                abort_run();
            end
            else if (wb_result.dest_reg_addr[4])
                check_result(wb_result, ld_q.pop_front(), "load");
            else
                check_result(wb_result, cvt_q.pop_front(), "convert");
        end
    endtask

    initial
    begin
        rst = 1'b1;
        cvt_valid = 1'b0;
        cvt_signed = 1'b0;
        cvt_dest_reg = '0;
        cvt_dest_offset = '0;
        cvt_a = '0;
        cvt_b = '0;
        cvt_op = fpx_pkg::CONVERT_OP_MIN;
        mem_valid = 1'b0;
        mem_dest_reg = '0;
        mem_dest_offset = '0;
        mem_op = fpx_pkg::MEMORY_OP_LOAD;
        mem_data = '0;
        mem_base = '0;
        mem_offset = '0;
        wb_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        // idle unit must stay quiet
        repeat (4)
        begin
            @(negedge clk);
            if (wb_valid !== 1'b0)
            begin
                $display("wb_valid went high at %0t before any command", $time);
                abort_run();
            end
        end
        while (cvt_sent < N_CVT || mem_sent < N_MEM || cvt_q.size() != 0 || ld_q.size() != 0)
        begin
            @(posedge clk);
            #1;
            drive_step();
            @(negedge clk);
            sample_step();
        end
        @(posedge clk);
        #1;
        cvt_valid = 1'b0;
        mem_valid = 1'b0;
        wb_ready = 1'b1;
        repeat (8)
        begin
            @(negedge clk);
            if (wb_valid !== 1'b0)
            begin
                $display("extra writeback at %0t after all results arrived", $time);
                abort_run();
            end
        end
        $display("Testbench passed");
        $finish;
    end

    initial
    begin
        repeat ((N_CVT + N_MEM) * 40 + RESET_CYCLES) @(posedge clk);
        $display("timeout at %0t with %0d convert and %0d load results still missing",
                 $time, cvt_q.size(), ld_q.size());
        abort_run();
    end

endmodule

/* tb.f */
verilog/fpx_pkg.sv
verilog/stream_stage.sv
verilog/fp_convert.sv
verilog/fp_memory.sv
verilog/writeback_arbiter.sv
verilog/fp_unit_top.sv
sim/fp_unit_tb.sv

/* Bender.yml */
package:
  name: fp_unit

sources:
  - files:
      - verilog/fpx_pkg.sv
      - verilog/stream_stage.sv
      - verilog/fp_convert.sv
      - verilog/fp_memory.sv
      - verilog/writeback_arbiter.sv
      - verilog/fp_unit_top.sv
  - target: simulation
    files:
      - sim/fp_unit_tb.sv
